// ==== design/tcb_pkg.sv ====
/*
 * tcb bus package
 * bus widths, byte-enable type and the address word union
 */
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // address and data width
  localparam int unsigned AW = 16;
  localparam int unsigned DW = 32;
  // one enable bit per data byte
  localparam int unsigned BW = DW / 8;

  // address field widths, region on top, byte lane at the bottom
  localparam int unsigned RW = 2;
  localparam int unsigned LW = $clog2(BW);
  localparam int unsigned IW = AW - RW - LW;

  // byte enable vector
  typedef logic [BW-1:0] tcb_ben_t;

  ////////////////////////////////////////
  // address word, flat or split into fields
  ////////////////////////////////////////

  typedef union packed {
    logic [AW-1:0] word;
    struct packed {
      logic [RW-1:0] region;
      logic [IW-1:0] index;
      // byte offset, ignored for word access
      logic [LW-1:0] lane;
    } fld;
  } tcb_adr_u;

endpackage

`default_nettype wire

// ==== design/tcb_map_pkg.sv ====
/*
 * tcb memory map package
 * region codes, csr word offsets and the id register value
 */
`default_nettype none

package tcb_map_pkg;

  ////////////////////////////////////////
  // regions, top bits of the address
  ////////////////////////////////////////

  // word memory
  localparam logic [tcb_pkg::RW-1:0] REG_MEM = 2'd0;
  // control and status registers
  localparam logic [tcb_pkg::RW-1:0] REG_CSR = 2'd1;
  // regions 2 and 3 are unmapped

  ////////////////////////////////////////
  // csr word indices
  ////////////////////////////////////////

  // read-only id
  localparam logic [tcb_pkg::IW-1:0] CSR_ID   = 12'd0;
  // scratch registers, byte writable
  localparam logic [tcb_pkg::IW-1:0] CSR_SCR0 = 12'd1;
  localparam logic [tcb_pkg::IW-1:0] CSR_SCR1 = 12'd2;

  // value returned by the id register
  localparam logic [tcb_pkg::DW-1:0] ID_VALUE = 32'h7cb0_0100;

endpackage

`default_nettype wire

// ==== design/tcb_if.sv ====
/*
 * tcb interface
 * request and response signals of one point to point link
 */
`timescale 1ns/1ns
`default_nettype none

interface tcb_if (
  input logic sub,
  input logic arst_n
);

  // request, driven by the manager
  logic                     vld;
  logic                     wen;
  tcb_pkg::tcb_ben_t        ben;
  tcb_pkg::tcb_adr_u        adr;
  logic [tcb_pkg::DW-1:0]   wdt;

  // response, driven by the subordinate a fixed delay later
  logic [tcb_pkg::DW-1:0]   rdt;
  logic                     err;

  // manager side
  modport man (
    input  sub,
    input  arst_n,
    output vld,
    output wen,
    output ben,
    output adr,
    output wdt,
    input  rdt,
    input  err
  );

  // subordinate side
  modport srv (
    input  sub,
    input  arst_n,
    input  vld,
    input  wen,
    input  ben,
    input  adr,
    input  wdt,
    output rdt,
    output err
  );

endinterface

`default_nettype wire

// ==== design/tcb_reg.sv ====
/*
 * tcb register slice
 * request and response paths, each one optionally registered
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_reg #(
  // register the request path
  parameter bit CFG_REQ_REG = 1'b1,
  // register the response path
  parameter bit CFG_RSP_REG = 1'b1
) (
  // manager connects here
  tcb_if.srv up,
  // subordinate connects here
  tcb_if.man dn
);

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  if (CFG_REQ_REG) begin : gen_req_reg

    // only the valid flag needs a reset
    always_ff @(posedge up.sub or negedge up.arst_n) begin
      if (!up.arst_n) begin
        dn.vld <= 1'b0;
      end else begin
        dn.vld <= up.vld;
      end
    end

    // payload follows the valid one cycle later
    always_ff @(posedge up.sub) begin
      dn.wen <= up.wen;
      dn.ben <= up.ben;
      dn.adr <= up.adr;
      dn.wdt <= up.wdt;
    end

  end else begin : gen_req_wire

    assign dn.vld = up.vld;
    assign dn.wen = up.wen;
    assign dn.ben = up.ben;
    assign dn.adr = up.adr;
    assign dn.wdt = up.wdt;

  end

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  if (CFG_RSP_REG) begin : gen_rsp_reg

    // no valid flag on the response, data and error just shift
    always_ff @(posedge dn.sub) begin
      up.rdt <= dn.rdt;
      up.err <= dn.err;
    end

  end else begin : gen_rsp_wire

    assign up.rdt = dn.rdt;
    assign up.err = dn.err;

  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // valid known on both sides once out of reset
  a_vld_known: assert property (
    @(posedge up.sub) disable iff (!up.arst_n)
    !$isunknown({up.vld, dn.vld})
  );

endmodule

`default_nettype wire

// ==== design/tcb_dec.sv ====
/*
 * tcb address decoder
 * routes requests to memory or csr, answers unmapped ones with an error
 * and steers the responses back by a registered select
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_dec #(
  // number of memory words
  parameter int unsigned MEM_WORDS = 256
) (
  tcb_if.srv up,
  tcb_if.man mem,
  tcb_if.man csr
);

  // request side select
  logic sel_mem;
  logic sel_csr;
  logic sel_err;

  // response side select, one cycle behind
  logic rsp_mem;
  logic rsp_csr;
  logic rsp_err;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  // memory region, index must be inside the array
  assign sel_mem = up.vld
                && (up.adr.fld.region == tcb_map_pkg::REG_MEM)
                && (32'(up.adr.fld.index) < MEM_WORDS);

  // csr region, the block itself checks the index
  assign sel_csr = up.vld && (up.adr.fld.region == tcb_map_pkg::REG_CSR);

  // everything else is answered here
  assign sel_err = up.vld && !sel_mem && !sel_csr;

  // valid only to the selected target
  assign mem.vld = sel_mem;
  assign csr.vld = sel_csr;

  // payload is shared by both targets
  assign mem.wen = up.wen;
  assign mem.ben = up.ben;
  assign mem.adr = up.adr;
  assign mem.wdt = up.wdt;

  assign csr.wen = up.wen;
  assign csr.ben = up.ben;
  assign csr.adr = up.adr;
  assign csr.wdt = up.wdt;

  ////////////////////////////////////////
  // response steering
  ////////////////////////////////////////

  // matches the one cycle target latency
  always_ff @(posedge up.sub or negedge up.arst_n) begin
    if (!up.arst_n) begin
      rsp_mem <= 1'b0;
      rsp_csr <= 1'b0;
      rsp_err <= 1'b0;
    end else begin
      rsp_mem <= sel_mem;
      rsp_csr <= sel_csr;
      rsp_err <= sel_err;
    end
  end

  // local error returns zero data
  assign up.rdt = rsp_mem ? mem.rdt :
                  rsp_csr ? csr.rdt : '0;
  assign up.err = rsp_mem ? mem.err :
                  rsp_csr ? csr.err : rsp_err;

  // never two targets at once
  a_sel_onehot: assert property (
    @(posedge up.sub) disable iff (!up.arst_n)
    $onehot0({mem.vld, csr.vld})
  );

endmodule

`default_nettype wire

// ==== design/tcb_mem.sv ====
/*
 * tcb word memory
 * byte-enabled writes, read data one cycle after the request
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_mem #(
  // number of words in the array
  parameter int unsigned MEM_WORDS = 256
) (
  tcb_if.srv bus
);

  // array address width
  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // storage, no reset
  logic [tcb_pkg::DW-1:0] mem_q [MEM_WORDS];
  // word address out of the index field
  logic [IDX_W-1:0]       idx;

  assign idx = bus.adr.fld.index[IDX_W-1:0];

  ////////////////////////////////////////
  // write and read
  ////////////////////////////////////////

  always_ff @(posedge bus.sub) begin
    if (bus.vld) begin
      if (bus.wen) begin
        // only enabled byte lanes change
        for (int b = 0; b < tcb_pkg::BW; b++) begin
          if (bus.ben[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
          end
        end
        // write returns no data
        bus.rdt <= '0;
      end else begin
        bus.rdt <= mem_q[idx];
      end
    end
  end

  // range is checked upstream, memory never refuses
  assign bus.err = 1'b0;

  // decoder must filter out of range words
  a_idx_range: assert property (
    @(posedge bus.sub) disable iff (!bus.arst_n)
    bus.vld |-> (32'(bus.adr.fld.index) < MEM_WORDS)
  );

endmodule

`default_nettype wire

// ==== design/tcb_csr.sv ====
/*
 * tcb control and status registers
 * read-only id, two byte-writable scratch words, error on illegal access
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_csr (
  tcb_if.srv bus
);

  // scratch storage
  logic [tcb_pkg::DW-1:0] scr0_q;
  logic [tcb_pkg::DW-1:0] scr1_q;

  // index hits
  logic hit_id;
  logic hit_scr0;
  logic hit_scr1;
  // refused access
  logic bad;
  // read mux output
  logic [tcb_pkg::DW-1:0] rd_mux;

  // merge new bytes into an old word under byte enables
  function automatic logic [tcb_pkg::DW-1:0] byte_merge(
    input logic [tcb_pkg::DW-1:0] old_w,
    input logic [tcb_pkg::DW-1:0] new_w,
    input tcb_pkg::tcb_ben_t      ben
  );
    logic [tcb_pkg::DW-1:0] res;
    res = old_w;
    for (int b = 0; b < tcb_pkg::BW; b++) begin
      if (ben[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign hit_id   = (bus.adr.fld.index == tcb_map_pkg::CSR_ID);
  assign hit_scr0 = (bus.adr.fld.index == tcb_map_pkg::CSR_SCR0);
  assign hit_scr1 = (bus.adr.fld.index == tcb_map_pkg::CSR_SCR1);

  // id is read only, nothing lives above scr1
  assign bad = bus.wen ? !(hit_scr0 || hit_scr1)
                       : !(hit_id || hit_scr0 || hit_scr1);

  // writes and refused reads give zero
  assign rd_mux = (bus.wen || bad) ? '0                    :
                  hit_id           ? tcb_map_pkg::ID_VALUE :
                  hit_scr0         ? scr0_q                : scr1_q;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge bus.sub or negedge bus.arst_n) begin
    if (!bus.arst_n) begin
      scr0_q  <= '0;
      scr1_q  <= '0;
      bus.err <= 1'b0;
    end else if (bus.vld) begin
      if (bus.wen && hit_scr0) scr0_q <= byte_merge(scr0_q, bus.wdt, bus.ben);
      if (bus.wen && hit_scr1) scr1_q <= byte_merge(scr1_q, bus.wdt, bus.ben);
      bus.err <= bad;
    end
  end

  // read data one cycle after the request
  always_ff @(posedge bus.sub) begin
    if (bus.vld) begin
      bus.rdt <= rd_mux;
    end
  end

  // decoder only sends csr region traffic here
  a_region: assert property (
    @(posedge bus.sub) disable iff (!bus.arst_n)
    bus.vld |-> (bus.adr.fld.region == tcb_map_pkg::REG_CSR)
  );

endmodule

`default_nettype wire

// ==== design/tcb_sys.sv ====
/*
 * tcb subsystem top
 * register slice, decoder, word memory and csr block on plain ports
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_sys #(
  // slice configuration
  parameter bit          CFG_REQ_REG = 1'b1,
  parameter bit          CFG_RSP_REG = 1'b1,
  // memory size in words
  parameter int unsigned MEM_WORDS   = 256
) (
  input  logic                   sub,
  input  logic                   arst_n,
  // request
  input  logic                   vld,
  input  logic                   wen,
  input  tcb_pkg::tcb_ben_t      ben,
  input  logic [tcb_pkg::AW-1:0] adr,
  input  logic [tcb_pkg::DW-1:0] wdt,
  // response, fixed latency
  output logic [tcb_pkg::DW-1:0] rdt,
  output logic                   err
);

  ////////////////////////////////////////
  // bus links
  ////////////////////////////////////////

  tcb_if bus_up  (.sub(sub), .arst_n(arst_n));
  tcb_if bus_dn  (.sub(sub), .arst_n(arst_n));
  tcb_if bus_mem (.sub(sub), .arst_n(arst_n));
  tcb_if bus_csr (.sub(sub), .arst_n(arst_n));

  // top ports onto the upstream link
  assign bus_up.vld = vld;
  assign bus_up.wen = wen;
  assign bus_up.ben = ben;
  assign bus_up.adr = adr;
  assign bus_up.wdt = wdt;

  assign rdt = bus_up.rdt;
  assign err = bus_up.err;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  tcb_reg #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG)
  ) i_reg (
    .up (bus_up),
    .dn (bus_dn)
  );

  tcb_dec #(
    .MEM_WORDS (MEM_WORDS)
  ) i_dec (
    .up  (bus_dn),
    .mem (bus_mem),
    .csr (bus_csr)
  );

  tcb_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) i_mem (
    .bus (bus_mem)
  );

  tcb_csr i_csr (
    .bus (bus_csr)
  );

endmodule

`default_nettype wire

// ==== bench/tcb_ref_model.svh ====
/*
 * tcb reference model
 * memory and csr contents, plus the queue of expected responses
 * MEM_WORDS and IDX_W come from the including module
 */
`ifndef TCB_REF_MODEL_SVH
`define TCB_REF_MODEL_SVH

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  // word memory and scratch registers as the bus should see them
  logic [tcb_pkg::DW-1:0] ref_mem [MEM_WORDS];
  logic [tcb_pkg::DW-1:0] ref_scr0;
  logic [tcb_pkg::DW-1:0] ref_scr1;

  // expected responses in request order, with the falling edge to check on
  logic [tcb_pkg::DW-1:0] exp_rdt_q [$];
  logic                   exp_err_q [$];
  int                     exp_due_q [$];

  // new bytes where the enable is set, old bytes elsewhere
  function automatic logic [tcb_pkg::DW-1:0] apply_ben(
    input logic [tcb_pkg::DW-1:0] old_w,
    input logic [tcb_pkg::DW-1:0] new_w,
    input tcb_pkg::tcb_ben_t      be
  );
    logic [tcb_pkg::DW-1:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // scratch registers clear on reset, memory keeps whatever it had
  task automatic model_reset();
    ref_scr0 = '0;
    ref_scr1 = '0;
  endtask

  // one request against the memory map, state updated at request time
  task automatic model_access(
    input  logic                   w,
    input  tcb_pkg::tcb_ben_t      be,
    input  logic [tcb_pkg::AW-1:0] a_word,
    input  logic [tcb_pkg::DW-1:0] d,
    output logic [tcb_pkg::DW-1:0] e_rdt,
    output logic                   e_err
  );
    tcb_pkg::tcb_adr_u a;
    logic [IDX_W-1:0]  wi;
    a.word = a_word;
    wi     = a.fld.index[IDX_W-1:0];
    e_rdt  = '0;
    e_err  = 1'b0;
    if ((a.fld.region == tcb_map_pkg::REG_MEM) && (32'(a.fld.index) < MEM_WORDS)) begin
      if (w) begin
        ref_mem[wi] = apply_ben(ref_mem[wi], d, be);
      end else begin
        e_rdt = ref_mem[wi];
      end
    end else if (a.fld.region == tcb_map_pkg::REG_CSR) begin
      case (a.fld.index)
        tcb_map_pkg::CSR_ID: begin
          // id is read only
          if (w) e_err = 1'b1;
          else e_rdt = tcb_map_pkg::ID_VALUE;
        end
        tcb_map_pkg::CSR_SCR0: begin
          if (w) ref_scr0 = apply_ben(ref_scr0, d, be);
          else e_rdt = ref_scr0;
        end
        tcb_map_pkg::CSR_SCR1: begin
          if (w) ref_scr1 = apply_ben(ref_scr1, d, be);
          else e_rdt = ref_scr1;
        end
        default: e_err = 1'b1;
      endcase
    end else begin
      // unmapped region or memory index past the array
      e_err = 1'b1;
    end
  endtask

`endif

// ==== bench/tcb_sys_tb.sv ====
/*
 * tcb subsystem testbench
 * directed and seeded random traffic, checked against a reference model
 */
`timescale 1ns/1ns
`default_nettype none

module tcb_sys_tb;

  // dut configuration
  localparam bit          CFG_REQ_REG = 1'b1;
  localparam bit          CFG_RSP_REG = 1'b1;
  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned IDX_W       = $clog2(MEM_WORDS);
  // request to response delay in cycles
  localparam int          LAT = int'(CFG_REQ_REG) + 1 + int'(CFG_RSP_REG);
  // number of word indices in a region
  localparam int unsigned IDX_SPAN = 1 << tcb_pkg::IW;

  // transactions per test
  localparam int N_INIT  = MEM_WORDS;
  localparam int N_BYTES = 240;
  localparam int N_CSR   = 48;
  localparam int N_ILL   = 40;
  localparam int N_UNMAP = 60;
  localparam int N_B2B   = 300;
  localparam int N_TOTAL = N_INIT + N_BYTES + N_CSR + N_ILL + N_UNMAP + N_B2B;
  // reset, at most two cycles per transaction, last latency, some slack
  localparam int CYC_LIMIT = 3 + N_TOTAL * 2 + LAT + 20;

  logic                   sub;
  logic                   arst_n;
  logic                   vld;
  logic                   wen;
  tcb_pkg::tcb_ben_t      ben;
  logic [tcb_pkg::AW-1:0] adr;
  logic [tcb_pkg::DW-1:0] wdt;
  logic [tcb_pkg::DW-1:0] rdt;
  logic                   err;

  // falling edge count, responses are checked against it
  int     cyc     = 0;
  integer seed    = 26328;
  int     errors  = 0;
  int     checks  = 0;
  int     tests   = 0;
  int     t_errors;
  int     t_checks;
  string  test_name;

  `include "tcb_ref_model.svh"

  tcb_sys #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG),
    .MEM_WORDS   (MEM_WORDS)
  ) i_dut (
    .sub    (sub),
    .arst_n (arst_n),
    .vld    (vld),
    .wen    (wen),
    .ben    (ben),
    .adr    (adr),
    .wdt    (wdt),
    .rdt    (rdt),
    .err    (err)
  );

  // 40 ns period
  always #20 sub = ~sub;

  ////////////////////////////////////////
  // random helpers
  ////////////////////////////////////////

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [tcb_pkg::DW-1:0] rnd32();
    logic [tcb_pkg::DW-1:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic tcb_pkg::tcb_ben_t rnd_ben();
    int unsigned r;
    r = rnd(16);
    return r[tcb_pkg::BW-1:0];
  endfunction

  // lane bits are random, the bus ignores them
  function automatic logic [tcb_pkg::AW-1:0] make_adr(
    input logic [tcb_pkg::RW-1:0] region,
    input int unsigned            index
  );
    tcb_pkg::tcb_adr_u a;
    int unsigned       ln;
    ln           = rnd(4);
    a.fld.region = region;
    a.fld.index  = index[tcb_pkg::IW-1:0];
    a.fld.lane   = ln[tcb_pkg::LW-1:0];
    return a.word;
  endfunction

  // fill value mixes every index bit
  function automatic logic [tcb_pkg::DW-1:0] fill_word(input int unsigned i);
    return (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  ////////////////////////////////////////
  // bus driving
  ////////////////////////////////////////

  task automatic send(
    input logic                   w,
    input tcb_pkg::tcb_ben_t      b,
    input logic [tcb_pkg::AW-1:0] a,
    input logic [tcb_pkg::DW-1:0] d
  );
    logic [tcb_pkg::DW-1:0] e_rdt;
    logic                   e_err;
    @(posedge sub);
    vld <= 1'b1;
    wen <= w;
    ben <= b;
    adr <= a;
    wdt <= d;
    model_access(w, b, a, d, e_rdt, e_err);
    exp_rdt_q.push_back(e_rdt);
    exp_err_q.push_back(e_err);
    // response sits on the falling edge LAT cycles after the capturing edge
    exp_due_q.push_back(cyc + 1 + LAT);
  endtask

  task automatic idle_cycle();
    @(posedge sub);
    vld <= 1'b0;
  endtask

  // stop requests and wait out every pending response
  task automatic drain();
    idle_cycle();
    while (exp_due_q.size() != 0) @(posedge sub);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    t_errors  = 0;
    t_checks  = 0;
  endtask

  task automatic end_test();
    drain();
    tests++;
    $display("test %-16s %4d checks  %0d errors  %s", test_name, t_checks, t_errors,
             (t_errors == 0) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////
  // response checking
  ////////////////////////////////////////

  always @(negedge sub) begin : check_rsp
    logic [tcb_pkg::DW-1:0] e_rdt;
    logic                   e_err;
    cyc = cyc + 1;
    if (exp_due_q.size() != 0) begin
      if (exp_due_q[0] <= cyc) begin
        e_rdt = exp_rdt_q.pop_front();
        e_err = exp_err_q.pop_front();
        void'(exp_due_q.pop_front());
        checks++;
        t_checks++;
        assert ((rdt === e_rdt) && (err === e_err)) else begin
          $display("[FAIL] %s: expected rdt=%08h err=%0b, actual rdt=%08h err=%0b",
                   test_name, e_rdt, e_err, rdt, err);
          errors++;
          t_errors++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  // every word gets a known value first, memory has no reset
  task automatic fill_memory();
    begin_test("mem_fill");
    for (int i = 0; i < N_INIT; i++) begin
      send(1'b1, '1, make_adr(tcb_map_pkg::REG_MEM, i), fill_word(i));
    end
    end_test();
  endtask

  // partial write then read back of the same word
  task automatic byte_lane_writes();
    logic [tcb_pkg::AW-1:0] a;
    begin_test("mem_byte_enable");
    for (int i = 0; i < N_BYTES / 2; i++) begin
      a = make_adr(tcb_map_pkg::REG_MEM, rnd(MEM_WORDS));
      send(1'b1, rnd_ben(), a, rnd32());
      send(1'b0, '0, a, '0);
      if (rnd(4) == 0) idle_cycle();
    end
    end_test();
  endtask

  task automatic csr_registers();
    int unsigned k;
    logic        w;
    begin_test("csr_access");
    // id, then both scratch words still at their reset value
    send(1'b0, '0, make_adr(tcb_map_pkg::REG_CSR, int'(tcb_map_pkg::CSR_ID)), '0);
    send(1'b0, '0, make_adr(tcb_map_pkg::REG_CSR, int'(tcb_map_pkg::CSR_SCR0)), '0);
    send(1'b0, '0, make_adr(tcb_map_pkg::REG_CSR, int'(tcb_map_pkg::CSR_SCR1)), '0);
    for (int i = 0; i < N_CSR - 3; i++) begin
      k = rnd(3);
      // legal only, no writes to id here
      w = (k != 0) && (rnd(2) == 1);
      send(w, rnd_ben(), make_adr(tcb_map_pkg::REG_CSR, int'(tcb_map_pkg::CSR_ID) + k), rnd32());
      if (rnd(4) == 0) idle_cycle();
    end
    end_test();
  endtask

  task automatic csr_illegal();
    int unsigned k;
    begin_test("csr_illegal");
    for (int i = 0; i < N_ILL / 2; i++) begin
      if (i % 2 == 0) begin
        k = int'(tcb_map_pkg::CSR_ID);
        send(1'b1, rnd_ben(), make_adr(tcb_map_pkg::REG_CSR, k), rnd32());
      end else begin
        k = int'(tcb_map_pkg::CSR_SCR1) + 1 + rnd(IDX_SPAN - 3);
        send(rnd(2) == 1, rnd_ben(), make_adr(tcb_map_pkg::REG_CSR, k), rnd32());
      end
    end
    // registers unchanged by the refused accesses
    for (int i = 0; i < N_ILL - N_ILL / 2; i++) begin
      k = int'(tcb_map_pkg::CSR_ID) + i % 3;
      send(1'b0, '0, make_adr(tcb_map_pkg::REG_CSR, k), '0);
    end
    end_test();
  endtask

  task automatic unmapped_access();
    logic [tcb_pkg::AW-1:0] a;
    int unsigned            r;
    begin_test("unmapped");
    for (int i = 0; i < 40; i++) begin
      if (i % 2 == 0) begin
        r = 2 + rnd(2);
        a = make_adr(r[1:0], rnd(IDX_SPAN));
      end else begin
        // memory region past the last word
        a = make_adr(tcb_map_pkg::REG_MEM, MEM_WORDS + rnd(IDX_SPAN - MEM_WORDS));
      end
      send(rnd(2) == 1, rnd_ben(), a, rnd32());
    end
    for (int i = 0; i < N_UNMAP - 40; i++) begin
      send(1'b0, '0, make_adr(tcb_map_pkg::REG_MEM, rnd(MEM_WORDS)), '0);
    end
    end_test();
  endtask

  // mixed targets in every cycle, mostly memory
  task automatic back_to_back();
    logic [tcb_pkg::AW-1:0] a;
    int unsigned            p;
    int unsigned            r;
    begin_test("back_to_back");
    for (int i = 0; i < N_B2B; i++) begin
      p = rnd(10);
      if (p < 6) begin
        a = make_adr(tcb_map_pkg::REG_MEM, rnd(MEM_WORDS + 4));
      end else if (p < 9) begin
        a = make_adr(tcb_map_pkg::REG_CSR, rnd(5));
      end else begin
        r = 2 + rnd(2);
        a = make_adr(r[1:0], rnd(IDX_SPAN));
      end
      send(rnd(2) == 1, rnd_ben(), a, rnd32());
    end
    end_test();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    sub    = 1'b0;
    arst_n = 1'b0;
    vld    = 1'b0;
    wen    = 1'b0;
    ben    = '0;
    adr    = '0;
    wdt    = '0;
    model_reset();
    repeat (3) @(posedge sub);
    arst_n <= 1'b1;

    fill_memory();
    byte_lane_writes();
    csr_registers();
    csr_illegal();
    unmapped_access();
    back_to_back();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cyc < CYC_LIMIT) @(posedge sub);
    $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tcb_sys.f ====
+incdir+bench
design/tcb_pkg.sv
design/tcb_map_pkg.sv
design/tcb_if.sv
design/tcb_reg.sv
design/tcb_dec.sv
design/tcb_mem.sv
design/tcb_csr.sv
design/tcb_sys.sv
bench/tcb_sys_tb.sv

// ==== Makefile ====
# tcb subsystem simulation with verilator

TOP = tcb_sys_tb

.PHONY: all lint clean

# build, run, then look for the pass line in the log
all: obj_dir/$(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

obj_dir/$(TOP): tcb_sys.f design/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -f tcb_sys.f --top-module $(TOP) -o $(TOP)

# design only, from the rtl top level
lint:
	verilator --lint-only --timing --assert -f tcb_sys.f --top-module tcb_sys

clean:
	rm -rf obj_dir sim.log
